//--- dv/quant_tests.txt
# W adr data : wishbone write | R adr data : wishbone read, expected data
# V acc0..acc7 q0..q7 : 24 bit lanes in, expected bytes out, lane 0 first, all hex
W 1 00000010
W 2 0000fff0
W 0 00000402
R 0 00000402
R 1 00000010
R 2 0000fff0
R 5 00000000
V ffffef 800000 ffff9c fffff0 00000f 000000 000010 ffffff 00 00 00 00 00 00 00 00
V 000000 0003ec 0003f0 7fffff 000110 00001f 001000 001010 04 ff ff ff 10 00 ff ff
V 000100 000100 000100 000100 000100 000100 000100 000100 44 44 44 44 0f 0f 0f 0f
W 0 00000100
V 000100 000100 000100 000100 000100 000100 000100 000100 ff ff ff ff 78 78 78 78
W 0 00002001
R 0 00002001
V 000000 0000f0 0001ee 0001f0 7fffff 000010 000100 ffffff 08 80 ff ff 00 00 00 00
V 000002 ffffef 00007f 400000 000020 000300 0000ab 123456 09 00 47 ff 00 00 00 00
V 000050 000051 0000ff fffff0 ffff00 ffff00 ffff00 ffff00 30 30 87 00 00 00 00 00
W 6 ffffffff
R 6 00000000
R 7 00000000
R 3 00000007
R 4 00000009

//--- quant_out_stage.f
logic/quant_pkg.sv
logic/wb_regs_pkg.sv
logic/quant_stage_if.sv
logic/quant_cfg_regs.sv
logic/bias_adder.sv
logic/relu_scale_quantizer.sv
logic/quant_out_stage.sv
dv/quant_out_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f quant_out_stage.f --top-module quant_out_stage_tb
out=$(./obj_dir/Vquant_out_stage_tb)
echo "$out"
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi

//--- dv/quant_out_stage_tb.sv
module quant_out_stage_tb import quant_pkg::*, wb_regs_pkg::*; ();

  logic clk;
  logic reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  wb_adr_t wb_adr;
  wb_dat_t wb_dat_w;
  wb_dat_t wb_dat_r;
  logic wb_ack;
  logic acc_valid;
  acc_vec_t acc_vector;
  logic q_valid;
  quant_vec_t q_vector;

  // free running edge count and timeout base
  int cycle = 0;
  int cycle_limit = 0;
  // monitor side counts
  int vector_errors = 0;
  int missing_errors = 0;
  // driver side counts
  int read_errors = 0;
  int bus_errors = 0;
  string lines[$];
  // expected vectors and the cycle their q_valid is due
  quant_vec_t exp_vec_q[$];
  int exp_due_q[$];
  // next expected entry the monitor looks at
  int mon_idx = 0;

  quant_out_stage dut (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .acc_valid  (acc_valid),
    .acc_vector (acc_vector),
    .q_valid    (q_valid),
    .q_vector   (q_vector)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////
  // checks and reporting
  //////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected, inout int errors);
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d vector, %0d missing q_valid, %0d read, %0d bus or file",
             vector_errors, missing_errors, read_errors, bus_errors);
  endtask

  // sample on the falling edge once outputs settle
  always @(negedge clk) begin
    if (q_valid) begin
      if (mon_idx >= exp_vec_q.size()) begin
        missing_errors++;
        $display("q_valid at time %0t with no vector in flight", $time);
      end else begin
        check_value("q_valid cycle", 64'(cycle), 64'(exp_due_q[mon_idx]), vector_errors);
        check_value("q_vector", 64'(q_vector), 64'(exp_vec_q[mon_idx]), vector_errors);
        mon_idx++;
      end
    end else if (mon_idx < exp_due_q.size() && cycle >= exp_due_q[mon_idx]) begin
      missing_errors++;
      $display("no q_valid at cycle %0d for vector number %0d", cycle, mon_idx);
      mon_idx++;
    end
  end

  initial begin : timeout_watch
    wait (cycle_limit > 0);
    while (cycle < cycle_limit) @(posedge clk);
    $display("timeout: the run did not end within %0d cycles", cycle_limit);
    report_counts();
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////
  // drivers
  //////////////////////////////

  // one wishbone classic cycle with the master holding until ack
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            output wb_dat_t rdat, output logic acked);
    int waited;
    waited = 0;
    acked = 1'b0;
    rdat = '0;
    @(posedge clk);
    acc_valid <= 1'b0;
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= dat;
    while (!acked && waited < 16) begin
      @(negedge clk);
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        rdat = wb_dat_r;
        // ack due in the cycle after the slave first sees the request
        check_value("wishbone ack cycle", 64'(waited), 64'(2), bus_errors);
      end
    end
    // write lands on this edge
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    if (!acked) begin
      bus_errors++;
      $display("no wishbone ack within 16 cycles for address %0d", adr);
    end
  endtask

  // q_valid due 3 edges after the drive edge
  task automatic send_vector(input acc_vec_t acc, input quant_vec_t expected);
    @(posedge clk);
    acc_valid <= 1'b1;
    acc_vector <= acc;
    exp_vec_q.push_back(expected);
    exp_due_q.push_back(cycle + 3);
  endtask

  // stop vectors and wait until every one came out
  task automatic drain_pipeline();
    @(posedge clk);
    acc_valid <= 1'b0;
    while (mon_idx < exp_vec_q.size()) @(posedge clk);
  endtask

  task automatic run_line(input string line);
    string kind;
    int n;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_dat_t rdat;
    logic acked;
    logic [acc_width-1:0] acc [lane_num];
    logic [quant_width-1:0] exb [lane_num];
    acc_vec_t acc_flat;
    quant_vec_t exp_flat;
    // skip blanks and comment lines
    if (line.len() < 2 || line.getc(0) == "#") begin
      return;
    end
    n = $sscanf(line, "%s", kind);
    if (kind == "W") begin
      n = $sscanf(line, "%s %h %h", kind, adr, dat);
      if (n != 3) begin
        bus_errors++;
        $display("malformed write line in tests file: %s", line);
      end else begin
        bus_access(1'b1, adr, dat, rdat, acked);
      end
    end else if (kind == "R") begin
      n = $sscanf(line, "%s %h %h", kind, adr, dat);
      if (n != 3) begin
        bus_errors++;
        $display("malformed read line in tests file: %s", line);
      end else begin
        // counters must see every vector first
        drain_pipeline();
        bus_access(1'b0, adr, '0, rdat, acked);
        if (acked) begin
          check_value($sformatf("read of address %0d", adr), 64'(rdat), 64'(dat), read_errors);
        end
      end
    end else if (kind == "V") begin
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", kind,
                  acc[0], acc[1], acc[2], acc[3], acc[4], acc[5], acc[6], acc[7],
                  exb[0], exb[1], exb[2], exb[3], exb[4], exb[5], exb[6], exb[7]);
      if (n != 17) begin
        bus_errors++;
        $display("malformed vector line in tests file: %s", line);
      end else begin
        // lane 0 in the low bits
        for (int i = 0; i < lane_num; i++) begin
          acc_flat[i*acc_width +: acc_width] = acc[i];
          exp_flat[i*quant_width +: quant_width] = exb[i];
        end
        send_vector(acc_flat, exp_flat);
      end
    end else begin
      bus_errors++;
      $display("unknown line in tests file: %s", line);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : run_tests
    int fd;
    string line;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    acc_valid = 1'b0;
    acc_vector = '0;
    fd = $fopen("dv/quant_tests.txt", "r");
    if (fd == 0) begin
      bus_errors++;
      $display("cannot open the tests file dv/quant_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 20 * lines.size() + 100;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    drain_pipeline();
    report_counts();
    if (vector_errors + missing_errors + read_errors + bus_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/quant_out_stage.sv
module quant_out_stage import quant_pkg::*, wb_regs_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  // wishbone config port
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_adr_t    wb_adr,
  input  wb_dat_t    wb_dat_w,
  output wb_dat_t    wb_dat_r,
  output logic       wb_ack,
  // array side
  input  logic       acc_valid,
  input  acc_vec_t   acc_vector,
  output logic       q_valid,
  output quant_vec_t q_vector
);

  scale_t [channel_num-1:0] scale_set;
  bias_t bias0;
  bias_t bias1;
  // clipped lanes of the current output vector
  sat_cnt_t sat_lanes;

  // bias adder to quantizer hop
  quant_stage_if stage_if ();

  //////////////////////////////
  // register block
  //////////////////////////////

  quant_cfg_regs u_cfg_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .q_valid   (q_valid),
    .sat_lanes (sat_lanes),
    .scale_set (scale_set),
    .bias0     (bias0),
    .bias1     (bias1)
  );

  //////////////////////////////
  // two stage data path
  //////////////////////////////

  bias_adder u_bias_adder (
    .clk        (clk),
    .reset      (reset),
    .acc_valid  (acc_valid),
    .acc_vector (acc_vector),
    .scale_set  (scale_set),
    .bias0      (bias0),
    .bias1      (bias1),
    .stage      (stage_if.src)
  );

  relu_scale_quantizer u_quantizer (
    .clk       (clk),
    .reset     (reset),
    .stage     (stage_if.dst),
    .q_valid   (q_valid),
    .q_vector  (q_vector),
    .sat_lanes (sat_lanes)
  );

endmodule

//--- logic/relu_scale_quantizer.sv
module relu_scale_quantizer import quant_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  quant_stage_if.dst stage,
  output logic       q_valid,
  output quant_vec_t q_vector,
  output sat_cnt_t   sat_lanes
);

  quant_vec_t q_next;
  // one flag per lane clipped to 255
  logic [lane_num-1:0] lane_sat;
  sat_cnt_t sat_next;

  //////////////////////////////
  // per lane relu and shift
  //////////////////////////////

  for (genvar i = 0; i < lane_num; i++) begin : g_lane
    scale_t lane_scale;
    logic lane_neg;
    logic [sum_width-1:0] lane_shift;

    // low group uses channel 0 shift
    assign lane_scale = (i < lanes_per_channel) ? stage.scale_lo : stage.scale_hi;
    assign lane_neg = stage.sum_lanes[i][sum_width-1];

    // shift of full width or more leaves nothing
    assign lane_shift = (lane_scale >= sum_width) ? '0
                        : ($unsigned(stage.sum_lanes[i]) >> lane_scale);

    // only a positive sum can clip
    assign lane_sat[i] = !lane_neg && (lane_shift > quant_max);

    // relu first then clip or pass the low byte
    assign q_next[i*quant_width +: quant_width] =
        lane_neg ? '0 :
        lane_sat[i] ? quant_t'(quant_max) :
        quant_t'(lane_shift);
  end

  //////////////////////////////
  // saturation count
  //////////////////////////////

  always_comb begin
    sat_next = '0;
    for (int i = 0; i < lane_num; i++) begin
      sat_next = sat_next + sat_cnt_t'(lane_sat[i]);
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= stage.valid;
    end
  end

  // vector holds between strobes
  always_ff @(posedge clk) begin
    if (stage.valid) begin
      q_vector <= q_next;
      sat_lanes <= sat_next;
    end
  end

  // strobed sums and shifts must be resolved values
  a_stage_known: assert property (
    @(posedge clk) disable iff (reset)
      stage.valid |-> !$isunknown({stage.sum_lanes, stage.scale_lo, stage.scale_hi})
  );

endmodule

//--- logic/bias_adder.sv
module bias_adder import quant_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     acc_valid,
  input  acc_vec_t                 acc_vector,
  input  scale_t [channel_num-1:0] scale_set,
  input  bias_t                    bias0,
  input  bias_t                    bias1,
  quant_stage_if.src               stage
);

  // bias per channel, indexed by lane group
  bias_t ch_bias [channel_num];
  sum_t [lane_num-1:0] sum_next;

  assign ch_bias[0] = bias0;
  assign ch_bias[1] = bias1;

  //////////////////////////////
  // lane sums
  //////////////////////////////

  // sign extend lane and bias, then add
  always_comb begin
    for (int i = 0; i < lane_num; i++) begin
      sum_next[i] = sum_t'(acc_t'(acc_vector[i*acc_width +: acc_width]))
                    + sum_t'(ch_bias[i / lanes_per_channel]);
    end
  end

  //////////////////////////////
  // stage register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= acc_valid;
    end
  end

  // scales travel with their sums, captured at the same edge
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      stage.sum_lanes <= sum_next;
      stage.scale_lo <= scale_set[0];
      stage.scale_hi <= scale_set[1];
    end
  end

  // quantizer and counters rely on a clean strobe
  a_valid_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(stage.valid)
  );

endmodule

//--- logic/quant_cfg_regs.sv
module quant_cfg_regs import quant_pkg::*, wb_regs_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  wb_adr_t                       wb_adr,
  input  wb_dat_t                       wb_dat_w,
  output wb_dat_t                       wb_dat_r,
  output logic                          wb_ack,
  input  logic                          q_valid,
  input  sat_cnt_t                      sat_lanes,
  output scale_t [channel_num-1:0]      scale_set,
  output bias_t                         bias0,
  output bias_t                         bias1
);

  wb_state_t state;
  // quantized vectors seen so far
  wb_dat_t vec_count;
  // clipped lanes seen so far
  wb_dat_t sat_count;

  //////////////////////////////
  // handshake fsm
  //////////////////////////////

  // idle -> ack for one cycle -> idle again
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (wb_cyc && wb_stb) begin
            state <= st_ack;
          end
        end
        st_ack: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  assign wb_ack = (state == st_ack);

  //////////////////////////////
  // config registers
  //////////////////////////////

  // write lands at the edge closing the ack cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      scale_set <= '0;
      bias0 <= '0;
      bias1 <= '0;
    end else if (wb_ack && wb_we) begin
      case (wb_adr)
        reg_scale: scale_set <= wb_dat_w[channel_num*scale_width-1:0];
        reg_bias0: bias0 <= bias_t'(wb_dat_w[bias_width-1:0]);
        reg_bias1: bias1 <= bias_t'(wb_dat_w[bias_width-1:0]);
        // counters and holes ignore writes
        default: ;
      endcase
    end
  end

  // read mux, master holds adr through ack
  always_comb begin
    case (wb_adr)
      reg_scale: wb_dat_r = wb_dat_t'(scale_set);
      // biases come back zero extended
      reg_bias0: wb_dat_r = wb_dat_t'($unsigned(bias0));
      reg_bias1: wb_dat_r = wb_dat_t'($unsigned(bias1));
      reg_vec_count: wb_dat_r = vec_count;
      reg_sat_count: wb_dat_r = sat_count;
      default: wb_dat_r = '0;
    endcase
  end

  //////////////////////////////
  // status counters
  //////////////////////////////

  // both wrap at 2^32
  always_ff @(posedge clk) begin
    if (reset) begin
      vec_count <= '0;
      sat_count <= '0;
    end else if (q_valid) begin
      vec_count <= vec_count + wb_dat_t'(1);
      sat_count <= sat_count + wb_dat_t'(sat_lanes);
    end
  end

  // ack only while the master still drives a cycle
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
  );

endmodule

//--- logic/quant_stage_if.sv
interface quant_stage_if import quant_pkg::*; ();

  // one cycle pulse per vector, no ready
  logic valid;
  // biased sums, lane 0 in element 0
  sum_t [lane_num-1:0] sum_lanes;
  // shift for lanes 0..3
  scale_t scale_lo;
  // shift for lanes 4..7
  scale_t scale_hi;

  // bias adder side
  modport src (
    output valid,
    output sum_lanes,
    output scale_lo,
    output scale_hi
  );

  // quantizer side
  modport dst (
    input valid,
    input sum_lanes,
    input scale_lo,
    input scale_hi
  );

endinterface

//--- logic/wb_regs_pkg.sv
package wb_regs_pkg;

  //////////////////////////////
  // wishbone bus widths
  //////////////////////////////

  localparam int wb_adr_width = 3;
  localparam int wb_dat_width = 32;

  // word address, no byte lanes
  typedef logic [wb_adr_width-1:0] wb_adr_t;
  typedef logic [wb_dat_width-1:0] wb_dat_t;

  //////////////////////////////
  // register map
  //////////////////////////////

  // bits 7:0 channel 0 shift, bits 15:8 channel 1 shift
  localparam wb_adr_t reg_scale = 3'd0;
  localparam wb_adr_t reg_bias0 = 3'd1;
  localparam wb_adr_t reg_bias1 = 3'd2;
  // read only counters
  localparam wb_adr_t reg_vec_count = 3'd3;
  localparam wb_adr_t reg_sat_count = 3'd4;

  // slave handshake states
  typedef enum logic {st_idle, st_ack} wb_state_t;

endpackage

//--- logic/quant_pkg.sv
package quant_pkg;

  //////////////////////////////
  // lane arrangement
  //////////////////////////////

  // lanes 0..3 feed channel 0, lanes 4..7 feed channel 1
  localparam int lanes_per_channel = 4;
  localparam int channel_num = 2;
  localparam int lane_num = lanes_per_channel * channel_num;

  //////////////////////////////
  // data path widths
  //////////////////////////////

  localparam int acc_width = 24;
  localparam int bias_width = 16;
  // 24 bit lane plus 16 bit bias never overflows 32 bits
  localparam int sum_width = 32;
  localparam int scale_width = 8;
  localparam int quant_width = 8;
  // largest unsigned byte, clip level
  localparam int quant_max = 255;

  typedef logic signed [acc_width-1:0] acc_t;
  typedef logic signed [bias_width-1:0] bias_t;
  typedef logic signed [sum_width-1:0] sum_t;
  typedef logic [scale_width-1:0] scale_t;
  typedef logic [quant_width-1:0] quant_t;
  // up to 8 clipped lanes per vector
  typedef logic [3:0] sat_cnt_t;

  // flat vectors as seen at the array boundary
  typedef logic [lane_num*acc_width-1:0] acc_vec_t;
  typedef logic [lane_num*quant_width-1:0] quant_vec_t;

endpackage
